// ==== include/rv_settings.svh ====
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// --------------------------------------------------
// Datapath width
// --------------------------------------------------
`define XLEN 32

// Sequential pc advance, one 32-bit instruction
`define PC_STEP 32'd4

// --------------------------------------------------
// RV32I major opcodes, instr[6:0]
// --------------------------------------------------
`define OPC_LUI    7'b0110111
`define OPC_AUIPC  7'b0010111
`define OPC_JAL    7'b1101111
`define OPC_JALR   7'b1100111
`define OPC_BRANCH 7'b1100011
`define OPC_LOAD   7'b0000011
`define OPC_STORE  7'b0100011
// Register-immediate arithmetic
`define OPC_OPIMM  7'b0010011
// Register-register arithmetic
`define OPC_OP     7'b0110011

`endif

// ==== logic/rv_pkg.sv ====
`include "rv_settings.svh"

package rv_pkg;

    // --------------------------------------------------
    // ALU operations
    // --------------------------------------------------
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        // Signed less-than, result in bit 0
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9,
        // Equality compare for BEQ and BNE
        ALU_EQ   = 4'd10
    } alu_op_t;

    // --------------------------------------------------
    // Immediate formats
    // --------------------------------------------------
    typedef enum logic [2:0] {
        IMM_I = 3'd0,
        IMM_S = 3'd1,
        IMM_B = 3'd2,
        IMM_U = 3'd3,
        IMM_J = 3'd4
    } imm_fmt_t;

    // Operand A source
    typedef enum logic [1:0] {
        SRC_A_RS1  = 2'd0,
        SRC_A_PC   = 2'd1,
        SRC_A_ZERO = 2'd2
    } src_a_t;

    // Operand B source
    typedef enum logic {
        SRC_B_RS2 = 1'b0,
        SRC_B_IMM = 1'b1
    } src_b_t;

    // --------------------------------------------------
    // Registered execute outcome
    // --------------------------------------------------
    typedef struct packed {
        // Writeback value, or effective address for memory ops
        logic [`XLEN-1:0] result;
        logic [4:0]       rd;
        logic             rd_wen;
        logic             mem_wen;
        logic             mem_ren;
        logic             branch_taken;
        // Redirect target for branches and jumps
        logic [`XLEN-1:0] target;
    } exec_result_t;

endpackage

// ==== logic/ctrl_if.sv ====
`timescale 1ns/1ps

interface ctrl_if;
    import rv_pkg::*;

    // Decoded control fields
    alu_op_t  alu_op;
    imm_fmt_t imm_fmt;
    src_a_t   src_a;
    src_b_t   src_b;

    // Writeback and memory enables
    logic rd_wen;
    logic mem_wen;
    logic mem_ren;

    // Flow control kind
    logic is_branch;
    logic is_jump;
    logic is_jalr;
    // Invert compare bit for BNE, BGE, BGEU
    logic br_inv;

    modport decoder (
        output alu_op, imm_fmt, src_a, src_b, rd_wen, mem_wen, mem_ren,
               is_branch, is_jump, is_jalr, br_inv
    );

    modport exec (
        input alu_op, imm_fmt, src_a, src_b, rd_wen, mem_wen, mem_ren,
              is_branch, is_jump, is_jalr, br_inv
    );

endinterface

// ==== logic/control_decoder.sv ====
`timescale 1ns/1ps
`include "rv_settings.svh"

module control_decoder (
    input  logic [6:0] opcode,
    input  logic [2:0] funct3,
    input  logic [6:0] funct7,
    ctrl_if.decoder    ctrl
);
    import rv_pkg::*;

    // --------------------------------------------------
    // Arithmetic op from funct3, shared by OP and OPIMM
    // --------------------------------------------------
    function automatic alu_op_t arith_op(
        input logic [2:0] f3,
        input logic       alt,
        input logic       reg_form
    );
        alu_op_t op;
        case (f3)
            // SUB only exists in register form
            3'b000:  op = (reg_form && alt) ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            // Arithmetic shift when funct7 bit 5 is set
            3'b101:  op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    // Branch compare kind from funct3[2:1]
    function automatic alu_op_t branch_op(input logic [1:0] f3_hi);
        alu_op_t op;
        case (f3_hi)
            2'b10:   op = ALU_SLT;
            2'b11:   op = ALU_SLTU;
            default: op = ALU_EQ;
        endcase
        return op;
    endfunction

    // --------------------------------------------------
    // Main decode
    // --------------------------------------------------
    always_comb begin
        // Defaults behave as add with no side effects
        ctrl.alu_op    = ALU_ADD;
        ctrl.imm_fmt   = IMM_I;
        ctrl.src_a     = SRC_A_RS1;
        ctrl.src_b     = SRC_B_IMM;
        ctrl.rd_wen    = 1'b0;
        ctrl.mem_wen   = 1'b0;
        ctrl.mem_ren   = 1'b0;
        ctrl.is_branch = 1'b0;
        ctrl.is_jump   = 1'b0;
        ctrl.is_jalr   = 1'b0;
        ctrl.br_inv    = 1'b0;

        case (opcode)
            `OPC_LUI: begin
                // Zero plus U immediate
                ctrl.imm_fmt = IMM_U;
                ctrl.src_a   = SRC_A_ZERO;
                ctrl.rd_wen  = 1'b1;
            end
            `OPC_AUIPC: begin
                ctrl.imm_fmt = IMM_U;
                ctrl.src_a   = SRC_A_PC;
                ctrl.rd_wen  = 1'b1;
            end
            `OPC_JAL: begin
                // ALU forms pc + imm as target
                ctrl.imm_fmt = IMM_J;
                ctrl.src_a   = SRC_A_PC;
                ctrl.rd_wen  = 1'b1;
                ctrl.is_jump = 1'b1;
            end
            `OPC_JALR: begin
                ctrl.rd_wen  = 1'b1;
                ctrl.is_jump = 1'b1;
                ctrl.is_jalr = 1'b1;
            end
            `OPC_BRANCH: begin
                // ALU compares rs1 and rs2, target adder uses pc
                ctrl.imm_fmt   = IMM_B;
                ctrl.src_b     = SRC_B_RS2;
                ctrl.alu_op    = branch_op(funct3[2:1]);
                ctrl.is_branch = 1'b1;
                // BNE, BGE, BGEU have funct3 bit 0 set
                ctrl.br_inv    = funct3[0];
            end
            `OPC_LOAD: begin
                ctrl.rd_wen  = 1'b1;
                ctrl.mem_ren = 1'b1;
            end
            `OPC_STORE: begin
                ctrl.imm_fmt = IMM_S;
                ctrl.mem_wen = 1'b1;
            end
            `OPC_OPIMM: begin
                ctrl.alu_op = arith_op(funct3, funct7[5], 1'b0);
                ctrl.rd_wen = 1'b1;
            end
            `OPC_OP: begin
                ctrl.src_b  = SRC_B_RS2;
                ctrl.alu_op = arith_op(funct3, funct7[5], 1'b1);
                ctrl.rd_wen = 1'b1;
            end
            default: begin
                // FENCE and unknown opcodes keep the defaults
                ctrl.rd_wen = 1'b0;
            end
        endcase
    end

endmodule

// ==== logic/imm_gen.sv ====
`timescale 1ns/1ps
`include "rv_settings.svh"

module imm_gen (
    input  logic [`XLEN-1:0] instr,
    input  rv_pkg::imm_fmt_t fmt,
    output logic [`XLEN-1:0] imm
);
    import rv_pkg::*;

    // Sign bit, common to every format
    logic sign;

    assign sign = instr[31];

    // --------------------------------------------------
    // Rebuild immediate by format
    // --------------------------------------------------
    always_comb begin
        case (fmt)
            IMM_S: begin
                // Split field, low part sits in the rd slot
                imm = {{20{sign}}, instr[31:25], instr[11:7]};
            end
            IMM_B: begin
                // Halfword offset, bit 0 always zero
                imm = {{19{sign}}, sign, instr[7], instr[30:25],
                       instr[11:8], 1'b0};
            end
            IMM_U: begin
                // Upper 20 bits, low 12 cleared
                imm = {instr[31:12], 12'b0};
            end
            IMM_J: begin
                imm = {{11{sign}}, sign, instr[19:12], instr[20],
                       instr[30:21], 1'b0};
            end
            default: begin
                // I format, also carries shift amounts
                imm = {{20{sign}}, instr[31:20]};
            end
        endcase
    end

endmodule

// ==== logic/alu_exec.sv ====
`timescale 1ns/1ps
`include "rv_settings.svh"

module alu_exec (
    input  logic                 clk,
    input  logic                 rst,
    ctrl_if.exec                 ctrl,
    input  logic                 in_valid,
    output logic                 in_ready,
    input  logic [4:0]           instr_rd,
    input  logic [`XLEN-1:0]     pc,
    input  logic [`XLEN-1:0]     rs1_data,
    input  logic [`XLEN-1:0]     rs2_data,
    input  logic [`XLEN-1:0]     imm,
    output logic                 out_valid,
    input  logic                 out_ready,
    output rv_pkg::exec_result_t out
);
    import rv_pkg::*;

    logic [`XLEN-1:0] op_a;
    logic [`XLEN-1:0] op_b;
    logic [`XLEN-1:0] alu_res;
    logic [4:0]       shamt;
    logic [`XLEN-1:0] pc_plus_imm;
    logic [`XLEN-1:0] jump_target;
    logic             taken;
    exec_result_t     exec_next;

    // --------------------------------------------------
    // Operand select
    // --------------------------------------------------
    always_comb begin
        case (ctrl.src_a)
            SRC_A_PC:   op_a = pc;
            SRC_A_ZERO: op_a = '0;
            default:    op_a = rs1_data;
        endcase
    end

    assign op_b  = (ctrl.src_b == SRC_B_IMM) ? imm : rs2_data;
    assign shamt = op_b[4:0];

    // --------------------------------------------------
    // ALU
    // --------------------------------------------------
    always_comb begin
        case (ctrl.alu_op)
            ALU_SUB:  alu_res = op_a - op_b;
            ALU_SLL:  alu_res = op_a << shamt;
            ALU_SLT:  alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
            ALU_SLTU: alu_res = {31'b0, op_a < op_b};
            ALU_XOR:  alu_res = op_a ^ op_b;
            ALU_SRL:  alu_res = op_a >> shamt;
            ALU_SRA:  alu_res = $signed(op_a) >>> shamt;
            ALU_OR:   alu_res = op_a | op_b;
            ALU_AND:  alu_res = op_a & op_b;
            ALU_EQ:   alu_res = {31'b0, op_a == op_b};
            default:  alu_res = op_a + op_b;
        endcase
    end

    // --------------------------------------------------
    // Branch and jump resolution
    // --------------------------------------------------
    // Branch target, ALU is busy with the compare
    assign pc_plus_imm = pc + imm;
    // JAL gets pc + imm from ALU, JALR drops bit 0
    assign jump_target = {alu_res[`XLEN-1:1], alu_res[0] & ~ctrl.is_jalr};
    assign taken = ctrl.is_jump | (ctrl.is_branch & (alu_res[0] ^ ctrl.br_inv));

    always_comb begin
        exec_next.rd           = instr_rd;
        exec_next.rd_wen       = ctrl.rd_wen;
        exec_next.mem_wen      = ctrl.mem_wen;
        exec_next.mem_ren      = ctrl.mem_ren;
        exec_next.branch_taken = taken;
        exec_next.target       = ctrl.is_jump ? jump_target : pc_plus_imm;
        // Link address for jumps, ALU value otherwise
        exec_next.result       = ctrl.is_jump ? (pc + `PC_STEP) : alu_res;
    end

    // --------------------------------------------------
    // Output register and handshake
    // --------------------------------------------------
    // Accept when slot empty or draining this edge
    assign in_ready = out_ready | ~out_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    // Payload held while stalled
    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out <= exec_next;
        end
    end

endmodule

// ==== logic/rv_decode_exec.sv ====
`timescale 1ns/1ps
`include "rv_settings.svh"

module rv_decode_exec (
    input  logic             clk,
    input  logic             rst,
    // Instruction side
    input  logic             in_valid,
    output logic             in_ready,
    input  logic [31:0]      instr,
    input  logic [`XLEN-1:0] pc,
    input  logic [`XLEN-1:0] rs1_data,
    input  logic [`XLEN-1:0] rs2_data,
    // Result side
    output logic             out_valid,
    input  logic             out_ready,
    output logic [`XLEN-1:0] out_result,
    output logic [4:0]       out_rd,
    output logic             out_rd_wen,
    output logic             out_mem_wen,
    output logic             out_mem_ren,
    output logic             out_branch_taken,
    output logic [`XLEN-1:0] out_target
);
    import rv_pkg::*;

    logic [`XLEN-1:0] imm;
    exec_result_t     exec_out;

    ctrl_if ctrl ();

    // --------------------------------------------------
    // Decode and immediate, side by side
    // --------------------------------------------------
    control_decoder u_dec (
        .opcode (instr[6:0]),
        .funct3 (instr[14:12]),
        .funct7 (instr[31:25]),
        .ctrl   (ctrl.decoder)
    );

    imm_gen u_imm (
        .instr (instr),
        .fmt   (ctrl.imm_fmt),
        .imm   (imm)
    );

    // Single register stage
    alu_exec u_exec (
        .clk       (clk),
        .rst       (rst),
        .ctrl      (ctrl.exec),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .instr_rd  (instr[11:7]),
        .pc        (pc),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .imm       (imm),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out       (exec_out)
    );

    // Unpack result onto plain ports
    assign out_result       = exec_out.result;
    assign out_rd           = exec_out.rd;
    assign out_rd_wen       = exec_out.rd_wen;
    assign out_mem_wen      = exec_out.mem_wen;
    assign out_mem_ren      = exec_out.mem_ren;
    assign out_branch_taken = exec_out.branch_taken;
    assign out_target       = exec_out.target;

endmodule

// ==== verif/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic rst
);
    // 8 ns period
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Reset high over the first four rising edges
    initial begin
        rst = 1'b1;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

// ==== verif/tb_rv_decode_exec.sv ====
`timescale 1ns/1ps
`include "rv_settings.svh"

module tb_rv_decode_exec;
    logic             clk, rst;
    logic             in_valid, in_ready, out_valid, out_ready;
    logic [31:0]      instr;
    logic [`XLEN-1:0] pc, rs1_data, rs2_data;
    logic [`XLEN-1:0] out_result, out_target;
    logic [4:0]       out_rd;
    logic             out_rd_wen, out_mem_wen, out_mem_ren, out_branch_taken;
    int               seed = 16;
    int               errors = 0;
    int               checks = 0;

    tb_clock_gen clk_gen (.clk(clk), .rst(rst));

    rv_decode_exec dut0 (.*);

    // --------------------------------------------------
    // Compare tasks
    // --------------------------------------------------
    task automatic check_word(input string name, input logic [`XLEN-1:0] got, exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s got 0x%08h expected 0x%08h", name, got, exp);
        end
    endtask

    task automatic check_rd(input string name, input logic [4:0] got, exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s got 0x%02h expected 0x%02h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    // --------------------------------------------------
    // Instruction encoders
    // --------------------------------------------------
    // Source fields fixed at x1 and x2 so operand values arrive as data
    function automatic logic [31:0] r_type(input logic alt, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {1'b0, alt, 5'b0, 5'd2, 5'd1, f3, rd, `OPC_OP};
    endfunction
    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [6:0] opc);
        return {imm, 5'd1, f3, rd, opc};
    endfunction
    function automatic logic [31:0] s_type(input logic [11:0] imm);
        return {imm[11:5], 5'd2, 5'd1, 3'b010, imm[4:0], `OPC_STORE};
    endfunction
    // Offset bit 0 is implied zero
    function automatic logic [31:0] b_type(input logic [12:0] off, input logic [2:0] f3);
        return {off[12], off[10:5], 5'd2, 5'd1, f3, off[4:1], off[11], `OPC_BRANCH};
    endfunction
    function automatic logic [31:0] j_type(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, `OPC_JAL};
    endfunction

    // --------------------------------------------------
    // Reference model of RV32I semantics
    // --------------------------------------------------
    function automatic logic [`XLEN-1:0] arith_ref(input logic [2:0] f3, input logic alt,
                                                   input logic [`XLEN-1:0] a, b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    return (a < b) ? 32'd1 : 32'd0;
            3'd4:    return a ^ b;
            3'd5:    return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    // BEQ BNE BLT BGE BLTU BGEU
    function automatic logic branch_ref(input logic [2:0] f3, input logic [`XLEN-1:0] a, b);
        case (f3)
            3'd0:    return a == b;
            3'd1:    return a != b;
            3'd4:    return $signed(a) < $signed(b);
            3'd5:    return $signed(a) >= $signed(b);
            3'd6:    return a < b;
            default: return a >= b;
        endcase
    endfunction

    // Drive one instruction and wait for its acceptance and its result
    task automatic run_instr(input logic [31:0] i, input logic [`XLEN-1:0] p, a, b);
        int t;
        @(posedge clk);
        in_valid <= 1'b1;
        instr    <= i;
        pc       <= p;
        rs1_data <= a;
        rs2_data <= b;
        t = 0;
        @(negedge clk);
        while (!in_ready && t < 50) begin
            @(negedge clk);
            t++;
        end
        if (!in_ready) begin
            errors++;
            $display("Timeout: the DUT never became ready for an instruction");
        end
        @(posedge clk);
        in_valid <= 1'b0;
        t = 0;
        @(negedge clk);
        while (!out_valid && t < 50) begin
            @(negedge clk);
            t++;
        end
        if (!out_valid) begin
            errors++;
            $display("Timeout: no result came out of the DUT");
        end
    endtask

    // --------------------------------------------------
    // Directed tests
    // --------------------------------------------------
    task automatic arith_ops();
        logic [`XLEN-1:0] a;
        logic [`XLEN-1:0] b;
        logic [11:0]      imm;
        logic [4:0]       rd;
        for (int f = 0; f < 8; f++) begin
            for (int alt = 0; alt < 2; alt++) begin
                a   = $random(seed);
                b   = $random(seed);
                rd  = $random(seed);
                imm = $random(seed);
                // funct7 bit 5 only picks SUB and SRA
                if (alt == 0 || f == 0 || f == 5) begin
                    run_instr(r_type(alt[0], f[2:0], rd), 32'h0, a, b);
                    check_word("out_result", out_result, arith_ref(f[2:0], alt[0], a, b));
                    check_rd("out_rd", out_rd, rd);
                    check_flag("out_rd_wen", out_rd_wen, 1'b1);
                end
                // Immediate form has no SUBI
                if (alt == 0 || f == 5) begin
                    if (f == 1 || f == 5) begin
                        imm[11:5] = {1'b0, alt[0], 5'b0};
                    end
                    run_instr(i_type(imm, f[2:0], rd, `OPC_OPIMM), 32'h0, a, 32'h0);
                    check_word("out_result", out_result,
                               arith_ref(f[2:0], alt[0], a, {{20{imm[11]}}, imm}));
                    check_rd("out_rd", out_rd, rd);
                    check_flag("out_rd_wen", out_rd_wen, 1'b1);
                end
            end
        end
    endtask

    task automatic upper_and_jumps();
        logic [19:0] up;
        logic [20:0] joff [2] = '{21'h1F_F800, 21'h00_0ABC};
        up = $random(seed);
        run_instr({up, 5'd3, `OPC_LUI}, 32'h0000_1000, 32'h0, 32'h0);
        check_word("out_result", out_result, {up, 12'h000});
        check_flag("out_rd_wen", out_rd_wen, 1'b1);
        run_instr({up, 5'd4, `OPC_AUIPC}, 32'h0000_2000, 32'h0, 32'h0);
        check_word("out_result", out_result, 32'h0000_2000 + {up, 12'h000});
        // JAL backward then forward
        for (int k = 0; k < 2; k++) begin
            run_instr(j_type(joff[k], 5'd1), 32'h0000_9000, 32'h0, 32'h0);
            check_word("out_result", out_result, 32'h0000_9004);
            check_word("out_target", out_target, 32'h0000_9000 + {{11{joff[k][20]}}, joff[k]});
            check_flag("out_branch_taken", out_branch_taken, 1'b1);
        end
        // JALR with an odd sum drops bit 0
        run_instr(i_type(12'hFFF, 3'b000, 5'd1, `OPC_JALR), 32'h0000_0200, 32'h4000, 32'h0);
        check_word("out_result", out_result, 32'h0000_0204);
        check_word("out_target", out_target, 32'h0000_3FFE);
        check_flag("out_branch_taken", out_branch_taken, 1'b1);
        check_flag("out_rd_wen", out_rd_wen, 1'b1);
    endtask

    task automatic branch_conditions();
        logic [2:0]       f3s [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
        // Equal, less, greater, then signed versus unsigned boundaries
        logic [`XLEN-1:0] as  [5] = '{32'd5, 32'd1, 32'd2, 32'h8000_0000, 32'hFFFF_FFFF};
        logic [`XLEN-1:0] bs  [5] = '{32'd5, 32'd2, 32'd1, 32'd1, 32'd0};
        logic [12:0]      off;
        for (int i = 0; i < 6; i++) begin
            for (int j = 0; j < 5; j++) begin
                off = j[0] ? 13'h0124 : 13'h1FF0;
                run_instr(b_type(off, f3s[i]), 32'h0000_0400, as[j], bs[j]);
                check_flag("out_branch_taken", out_branch_taken,
                           branch_ref(f3s[i], as[j], bs[j]));
                check_word("out_target", out_target, 32'h0000_0400 + {{19{off[12]}}, off});
                check_flag("out_rd_wen", out_rd_wen, 1'b0);
            end
        end
    endtask

    task automatic load_store();
        logic [11:0]      offs [3] = '{12'h7FF, 12'h800, 12'hFFC};
        logic [`XLEN-1:0] base;
        for (int k = 0; k < 3; k++) begin
            base = $random(seed);
            run_instr(i_type(offs[k], 3'b010, 5'd7, `OPC_LOAD), 32'h0, base, 32'h0);
            check_word("out_result", out_result, base + {{20{offs[k][11]}}, offs[k]});
            check_flag("out_mem_ren", out_mem_ren, 1'b1);
            check_flag("out_mem_wen", out_mem_wen, 1'b0);
            check_flag("out_rd_wen", out_rd_wen, 1'b1);
            run_instr(s_type(offs[k]), 32'h0, base, 32'hDEAD_BEEF);
            check_word("out_result", out_result, base + {{20{offs[k][11]}}, offs[k]});
            check_flag("out_mem_wen", out_mem_wen, 1'b1);
            check_flag("out_mem_ren", out_mem_ren, 1'b0);
            check_flag("out_rd_wen", out_rd_wen, 1'b0);
        end
    endtask

    task automatic stall_and_burst();
        logic [11:0]      imm;
        logic [4:0]       rd;
        logic [`XLEN-1:0] base;
        @(posedge clk);
        out_ready <= 1'b0;
        run_instr(i_type(12'h010, 3'b000, 5'd5, `OPC_OPIMM), 32'h0, 32'h100, 32'h0);
        // Next instruction waits while the result is held
        @(posedge clk);
        in_valid <= 1'b1;
        instr    <= i_type(12'h020, 3'b000, 5'd6, `OPC_OPIMM);
        rs1_data <= 32'h200;
        repeat (5) begin
            @(negedge clk);
            check_flag("in_ready", in_ready, 1'b0);
            check_flag("out_valid", out_valid, 1'b1);
            check_word("out_result", out_result, 32'h110);
            check_rd("out_rd", out_rd, 5'd5);
        end
        @(posedge clk);
        out_ready <= 1'b1;
        // Held result drains and the waiting one is taken on the same edge
        @(posedge clk);
        in_valid <= 1'b0;
        @(negedge clk);
        check_flag("out_valid", out_valid, 1'b1);
        check_word("out_result", out_result, 32'h220);
        check_rd("out_rd", out_rd, 5'd6);
        // Burst of four gives one result per cycle in order
        for (int k = 0; k <= 4; k++) begin
            @(posedge clk);
            imm  = k + 1;
            rd   = k + 8;
            base = 32'h1000 * (k + 1);
            in_valid <= (k < 4);
            instr    <= i_type(imm, 3'b000, rd, `OPC_OPIMM);
            rs1_data <= base;
            if (k > 0) begin
                @(negedge clk);
                check_flag("out_valid", out_valid, 1'b1);
                check_flag("in_ready", in_ready, 1'b1);
                check_word("out_result", out_result, 32'h1000 * k + k);
                check_rd("out_rd", out_rd, k + 7);
            end
        end
    endtask

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------
    initial begin
        int t;
        in_valid  = 1'b0;
        instr     = 32'h0;
        pc        = 32'h0;
        rs1_data  = 32'h0;
        rs2_data  = 32'h0;
        // Sink stalled through reset so in_ready follows the cleared slot
        out_ready = 1'b0;
        t = 0;
        @(posedge clk);
        while (rst && t < 20) begin
            @(posedge clk);
            t++;
        end
        if (rst) begin
            errors++;
            $display("Timeout: reset was never released");
        end
        // Empty output slot after reset
        @(negedge clk);
        check_flag("out_valid", out_valid, 1'b0);
        check_flag("in_ready", in_ready, 1'b1);
        @(posedge clk);
        out_ready <= 1'b1;
        arith_ops();
        upper_and_jumps();
        branch_conditions();
        load_store();
        stall_and_burst();
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== rv_decode_exec.f ====
+incdir+include
logic/rv_pkg.sv
logic/ctrl_if.sv
logic/control_decoder.sv
logic/imm_gen.sv
logic/alu_exec.sv
logic/rv_decode_exec.sv
verif/tb_clock_gen.sv
verif/tb_rv_decode_exec.sv
